/* verilog/display_pkg.sv */
// Fixed 16x4 RGB332 to RGB565 geometry; FIFO_DEPTH is assumed to be a power of two
package display_pkg;

    // Frame geometry in pixels and lines
    localparam int LINE_PIXELS = 16;
    localparam int FRAME_LINES = 4;

    // Entries held between expander and tagger
    localparam int FIFO_DEPTH = 4;

    // Counter widths derived from the geometry
    localparam int COL_W = $clog2(LINE_PIXELS);
    localparam int ROW_W = $clog2(FRAME_LINES);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    // One extra bit so a full FIFO can be told apart from an empty one
    localparam int CNT_W = PTR_W + 1;

    // Compressed input, red 7:5, green 4:2, blue 1:0
    typedef logic [7:0] rgb332_t;

    // Expanded output, red 15:11, green 10:5, blue 4:0
    typedef logic [15:0] rgb565_t;

    typedef logic [COL_W-1:0] col_t;
    typedef logic [ROW_W-1:0] row_t;

    // FIFO bookkeeping
    typedef logic [PTR_W-1:0] fifo_ptr_t;
    typedef logic [CNT_W-1:0] fifo_cnt_t;

    // Word handed to the frame writer, 24 bits
    typedef struct packed {
        rgb565_t rgb;
        col_t    col;
        row_t    row;
        logic    eol;
        logic    eof;
    } tagged_pixel_t;

endpackage

/* verilog/rgb332_expander.sv */
// One output register and no skid buffer; low bits of every RGB565 field are zero-filled
`timescale 1ns/1ps

module rgb332_expander
    import display_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // Compressed pixel stream
    input  rgb332_t pix,
    input  logic    pix_valid,
    output logic    pix_ready,
    // Expanded pixel stream
    output rgb565_t exp_word,
    output logic    exp_valid,
    input  logic    exp_ready
);

    // Output register contents
    rgb565_t word_q;
    logic    full_q;
    logic    take;

    // Place each field at the top of its wider field
    function automatic rgb565_t expand(input rgb332_t p);
        rgb565_t w;
        // Red 3 bits over 2 zeros
        w[15:11] = {p[7:5], 2'b00};
        // Green 3 bits over 3 zeros
        w[10:5]  = {p[4:2], 3'b000};
        // Blue 2 bits over 3 zeros
        w[4:0]   = {p[1:0], 3'b000};
        return w;
    endfunction

    // Open when empty or draining this cycle, so no bubble
    assign pix_ready = !full_q || exp_ready;
    assign take      = pix_valid && pix_ready;

    // Occupancy flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (take) begin
            full_q <= 1'b1;
        end else if (exp_ready) begin
            // Drained with nothing behind it
            full_q <= 1'b0;
        end
    end

    // Payload, loaded already widened
    always_ff @(posedge clk) begin
        if (take) begin
            word_q <= expand(pix);
        end
    end

    assign exp_word  = word_q;
    assign exp_valid = full_q;

    // A stalled word must neither vanish nor change until taken
    a_exp_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        exp_valid && !exp_ready |=> exp_valid && $stable(exp_word)
    );

endmodule

/* verilog/pixel_fifo.sv */
// No bypass, so an empty FIFO adds one cycle; wr_ready ignores a pop in the same cycle
`timescale 1ns/1ps

module pixel_fifo
    import display_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // Write side
    input  rgb565_t wr_word,
    input  logic    wr_valid,
    output logic    wr_ready,
    // Read side
    output rgb565_t rd_word,
    output logic    rd_valid,
    input  logic    rd_ready
);

    // Storage
    rgb565_t   mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      push;
    logic      pop;

    // Full only when every entry is in use
    assign wr_ready = count < fifo_cnt_t'(FIFO_DEPTH);
    assign rd_valid = count != '0;
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;

    // Head of the queue, read straight from storage
    assign rd_word = mem[rd_ptr];

    // Entries are written only, never cleared
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // Pointers wrap at the last entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= fifo_cnt_t'(FIFO_DEPTH)
    );

    // Empty means pointers have met and nothing leaves
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        count == '0 |-> !pop && rd_ptr == wr_ptr
    );

endmodule

/* verilog/raster_tagger.sv */
// Counts from reset only; no sync input, so a lost word shifts all later tags
`timescale 1ns/1ps

module raster_tagger
    import display_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    // Word stream from the FIFO
    input  rgb565_t       word,
    input  logic          word_valid,
    output logic          word_ready,
    // Tagged stream to the frame writer
    output tagged_pixel_t out_pix,
    output logic          out_valid,
    input  logic          out_ready
);

    // Position of the next accepted word
    col_t col;
    row_t row;
    logic last_col;
    logic last_row;
    logic take;

    assign last_col   = col == col_t'(LINE_PIXELS - 1);
    assign last_row   = row == row_t'(FRAME_LINES - 1);
    // Same rule as the expander
    assign word_ready = !out_valid || out_ready;
    assign take       = word_valid && word_ready;

    // Raster counters and valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col       <= '0;
            row       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (take) begin
                out_valid <= 1'b1;
                if (last_col) begin
                    col <= '0;
                    // Line wraps at end of frame
                    row <= last_row ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Tagged payload
    always_ff @(posedge clk) begin
        if (take) begin
            out_pix.rgb <= word;
            out_pix.col <= col;
            out_pix.row <= row;
            out_pix.eol <= last_col;
            out_pix.eof <= last_col && last_row;
        end
    end

    // End of frame only on the final corner, after which counting restarts
    a_eof_corner: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && out_pix.eof |-> out_pix.eol && out_pix.row == row_t'(FRAME_LINES - 1)
            && col == '0 && row == '0
    );

endmodule

/* verilog/display_codec_top.sv */
// Latency is two edges with no stalls; stalled, it holds six pixels in flight
`timescale 1ns/1ps

module display_codec_top
    import display_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    // RGB332 pixel input
    input  rgb332_t       pix,
    input  logic          pix_valid,
    output logic          pix_ready,
    // Tagged RGB565 output
    output tagged_pixel_t out_pix,
    output logic          out_valid,
    input  logic          out_ready
);

    // Expander to FIFO
    rgb565_t exp_word;
    logic    exp_valid;
    logic    exp_ready;

    // FIFO to tagger
    rgb565_t buf_word;
    logic    buf_valid;
    logic    buf_ready;

    // Widen each pixel
    rgb332_expander rgb332_expander_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix       (pix),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .exp_word  (exp_word),
        .exp_valid (exp_valid),
        .exp_ready (exp_ready)
    );

    // Absorbs downstream stalls
    pixel_fifo pixel_fifo_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_word  (exp_word),
        .wr_valid (exp_valid),
        .wr_ready (exp_ready),
        .rd_word  (buf_word),
        .rd_valid (buf_valid),
        .rd_ready (buf_ready)
    );

    // Attach raster position
    raster_tagger raster_tagger_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .word       (buf_word),
        .word_valid (buf_valid),
        .word_ready (buf_ready),
        .out_pix    (out_pix),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

/* dv/tb_display_codec.sv */
// Needs dv/display_golden.hex from the project root; checks two 16x4 frames in order
`timescale 1ns/1ps

module tb_display_codec
    import display_pkg::*;
;

    localparam int FRAME_PIX   = LINE_PIXELS * FRAME_LINES;
    localparam int TOTAL_PIX   = 2 * FRAME_PIX;
    localparam int RESET_CYC   = 8;
    localparam int CYCLE_LIMIT = 20 * TOTAL_PIX + RESET_CYC;

    logic          clk = 1'b0;
    logic          rst_n;
    rgb332_t       pix;
    logic          pix_valid;
    logic          pix_ready;
    tagged_pixel_t out_pix;
    logic          out_valid;
    logic          out_ready;

    // Pixel in 23:16 and expected RGB565 in 15:0
    logic [23:0] golden [FRAME_PIX];
    rgb565_t     exp_q [$];
    int          cycle = 0;
    int          idx = 0;
    int          out_count = 0;
    int          errors = 0;
    int          first_accept_edge = -1;
    int          first_valid_edge = -1;
    logic        rand_ready = 1'b0;
    logic        accepted;

    display_codec_top display_codec_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix       (pix),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .out_pix   (out_pix),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #50 clk = ~clk;

    // Flags any difference, X and Z included
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Edge counter and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles with %0d outputs", cycle, out_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Output monitor with tags derived from the output index
    always @(posedge clk) begin
        if (rst_n && out_valid && first_valid_edge < 0) begin
            first_valid_edge = cycle - 1;
        end
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0 || out_count >= TOTAL_PIX) begin
                $display("Output at t=%0t has no matching input pixel", $time);
                errors++;
            end else begin
                check_value("out_pix.rgb", exp_q.pop_front(), out_pix.rgb);
                check_value("out_pix.col", out_count % LINE_PIXELS, out_pix.col);
                check_value("out_pix.row", (out_count / LINE_PIXELS) % FRAME_LINES, out_pix.row);
                check_value("out_pix.eol", (out_count % LINE_PIXELS) == LINE_PIXELS - 1,
                            out_pix.eol);
                check_value("out_pix.eof", (out_count % FRAME_PIX) == FRAME_PIX - 1,
                            out_pix.eof);
            end
            out_count++;
        end
    end

    // Drive one cycle just after an edge and sample the handshake at the next edge
    task automatic step(input logic want);
        pix       = golden[idx % FRAME_PIX][23:16];
        pix_valid = want && (idx < TOTAL_PIX);
        // Random back-pressure only in the stream test
        if (rand_ready) begin
            out_ready = ($urandom % 3) != 0;
        end
        @(posedge clk);
        accepted = pix_valid && pix_ready;
        if (accepted) begin
            if (idx == 0) begin
                first_accept_edge = cycle;
            end
            exp_q.push_back(golden[idx % FRAME_PIX][15:0]);
            idx++;
        end
        #1;
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %s: %s (%0d errors)", name,
                 (errors == err_before) ? "ok" : "failed", errors - err_before);
    endtask

    initial begin
        int err_before;
        int accepts;
        void'($urandom(32'he8b1cec8));
        $readmemh("dv/display_golden.hex", golden);
        rst_n     = 1'b0;
        pix       = '0;
        pix_valid = 1'b0;
        out_ready = 1'b0;

        // Reset state
        err_before = errors;
        repeat (RESET_CYC) begin
            @(posedge clk);
            check_value("out_valid", 0, out_valid);
        end
        #1;
        rst_n = 1'b1;
        check_value("out_valid", 0, out_valid);
        @(posedge clk);
        #1;
        check_value("pix_ready", 1, pix_ready);
        report("reset", err_before);

        // Throughput and two-edge latency from an empty path
        err_before = errors;
        out_ready = 1'b1;
        accepts = 0;
        repeat (10) begin
            step(1'b1);
            accepts += accepted;
        end
        check_value("accepts", 10, accepts);
        check_value("latency", 2, first_valid_edge - first_accept_edge);
        while (out_count < idx) step(1'b0);
        report("throughput", err_before);

        // Capacity with the output stalled
        err_before = errors;
        out_ready = 1'b0;
        accepts = 0;
        repeat (12) begin
            step(1'b1);
            accepts += accepted;
        end
        check_value("accepts", FIFO_DEPTH + 2, accepts);
        check_value("pix_ready", 0, pix_ready);
        out_ready = 1'b1;
        while (out_count < idx) step(1'b0);
        report("capacity", err_before);

        // Rest of both frames with random gaps and back-pressure
        err_before = errors;
        rand_ready = 1'b1;
        while (idx < TOTAL_PIX) step(($urandom % 4) != 0);
        while (out_count < idx) step(1'b0);
        rand_ready = 1'b0;
        out_ready = 1'b1;
        repeat (4) step(1'b0);
        check_value("out_count", TOTAL_PIX, out_count);
        check_value("queue_left", 0, exp_q.size());
        report("stream", err_before);

        $display("done: %0d pixels in, %0d out, %0d errors", idx, out_count, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* dv/display_golden.hex */
// Columns: pixel RGB332 (2 hex digits) then expected RGB565 (4 hex digits)
// One 16x4 frame, one entry per pixel in raster order
000000
040100
080200
0C0300
100400
140500
180600
1C0700
202000
242100
282200
2C2300
302400
342500
382600
3C2700
414008
454108
494208
4D4308
514408
554508
594608
5D4708
616008
656108
696208
6D6308
716408
756508
796608
7D6708
828010
868110
8A8210
8E8310
928410
968510
9A8610
9E8710
A2A010
A6A110
AAA210
AEA310
B2A410
B6A510
BAA610
BEA710
C3C018
C7C118
CBC218
CFC318
D3C418
D7C518
DBC618
DFC718
E3E018
E7E118
EBE218
EFE318
F3E418
F7E518
FBE618
FFE718

/* build.f */
verilog/display_pkg.sv
verilog/rgb332_expander.sv
verilog/pixel_fifo.sv
verilog/raster_tagger.sv
verilog/display_codec_top.sv
dv/tb_display_codec.sv

/* Bender.yml */
package:
  name: display_codec

sources:
  - verilog/display_pkg.sv
  - verilog/rgb332_expander.sv
  - verilog/pixel_fifo.sv
  - verilog/raster_tagger.sv
  - verilog/display_codec_top.sv
  - target: simulation
    files:
      - dv/tb_display_codec.sv
